/* design/cart_pkg.sv */
`default_nettype none

package cart_pkg;

	// Chip ID and map mode.
	typedef struct packed {
		logic [3:0] chip;
		logic [3:0] map_mode;
	} chip_view_t;

	// Top two bits mark DSPn carts.
	typedef struct packed {
		logic [1:0] dsp_class;
		logic [5:0] rest;
	} dsp_view_t;

	typedef union packed {
		chip_view_t chip_view;
		dsp_view_t  dsp_view;
	} cart_type_t;

	typedef enum logic [1:0] {
		MAP_BASE = 2'd0,
		MAP_GSU  = 2'd1,
		MAP_SA1  = 2'd2
	} map_sel_t;

	localparam logic [3:0] CHIP_NONE = 4'h0;
	localparam logic [3:0] CHIP_SA1  = 4'h6;
	localparam logic [3:0] CHIP_GSU  = 4'h7;
	localparam logic [1:0] DSP_CLASS = 2'b10;

endpackage

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	typedef logic [7:0]  data_t;
	typedef logic [15:0] rom_data_t;

	// Default memory sizes.
	localparam int ROM_ADDR_W   = 24;
	localparam int BSRAM_ADDR_W = 20;

	// Audio RAM is 64 KiB.
	localparam int ARAM_ADDR_W  = 16;
	localparam int EXT_ADDR_W   = 20;

endpackage

`default_nettype wire

/* design/cart_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Outputs of one cartridge mapper.
interface mapper_bus_if #(
	parameter int ROM_ADDR_W   = bus_pkg::ROM_ADDR_W,
	parameter int BSRAM_ADDR_W = bus_pkg::BSRAM_ADDR_W
);
	import bus_pkg::*;

	logic [ROM_ADDR_W-1:0]   rom_addr;
	logic                    rom_ce_n;
	logic                    rom_oe_n;
	logic                    rom_word;
	logic [BSRAM_ADDR_W-1:0] bsram_addr;
	data_t                   bsram_d;
	logic                    bsram_ce_n;
	logic                    bsram_oe_n;
	logic                    bsram_we_n;
	data_t                   cpu_do;
	logic                    irq_n;

	modport src (output rom_addr, rom_ce_n, rom_oe_n, rom_word, bsram_addr, bsram_d,
		bsram_ce_n, bsram_oe_n, bsram_we_n, cpu_do, irq_n);
	modport sink (input rom_addr, rom_ce_n, rom_oe_n, rom_word, bsram_addr, bsram_d,
		bsram_ce_n, bsram_oe_n, bsram_we_n, cpu_do, irq_n);
endinterface

// Savestate engine bus overrides.
interface ss_bus_if #(
	parameter int ROM_ADDR_W = bus_pkg::ROM_ADDR_W
);
	import bus_pkg::*;

	data_t                 ss_do;
	logic [EXT_ADDR_W-1:0] ext_addr;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic                  aram_sel;
	logic                  bsram_sel;
	logic                  do_ovr;
	logic                  rom_ovr;
	logic                  pard_n;
	logic                  pawr_n;

	modport src (output ss_do, ext_addr, rom_addr, aram_sel, bsram_sel, do_ovr, rom_ovr,
		pard_n, pawr_n);
	modport sink (input ss_do, ext_addr, rom_addr, aram_sel, bsram_sel, do_ovr, rom_ovr,
		pard_n, pawr_n);
endinterface

`default_nettype wire

/* design/map_control.sv */
`timescale 1ns/1ps
`default_nettype none

module map_control (
	input  logic                 mclk,
	input  logic                 rst,
	input  cart_pkg::cart_type_t cart_type,
	input  logic                 ss_busy,
	output cart_pkg::map_sel_t   map_sel,
	output logic                 ss_avail,
	output logic                 turbo_allow,
	output logic                 gsu_active
);
	import cart_pkg::*;

	map_sel_t sel_next;
	logic     avail_next;

	always_comb begin
		case (cart_type.chip_view.chip)
			CHIP_GSU: sel_next = MAP_GSU;
			CHIP_SA1: sel_next = MAP_SA1;
			default:  sel_next = MAP_BASE;
		endcase
	end

	// Plain carts, DSPn carts, SA-1 and GSU can be saved.
	assign avail_next = (cart_type.chip_view.chip == CHIP_NONE) ||
		(cart_type.dsp_view.dsp_class == DSP_CLASS) ||
		(sel_next == MAP_SA1) || (sel_next == MAP_GSU);

	always_ff @(posedge mclk) begin
		if (rst) begin
			map_sel     <= MAP_BASE;
			ss_avail    <= 1'b0;
			turbo_allow <= 1'b0;
			gsu_active  <= 1'b0;
		end else begin
			map_sel     <= sel_next;
			ss_avail    <= avail_next;
			// No turbo on SA-1 or while a savestate runs.
			turbo_allow <= !((sel_next == MAP_SA1) || ss_busy);
			gsu_active  <= (sel_next == MAP_GSU);
		end
	end

endmodule

`default_nettype wire

/* design/rom_bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_bus_mux #(
	parameter int ROM_ADDR_W = bus_pkg::ROM_ADDR_W
) (
	input  logic                  mclk,
	input  logic                  rst,
	input  cart_pkg::map_sel_t    map_sel,
	mapper_bus_if.sink            base,
	mapper_bus_if.sink            gsu,
	mapper_bus_if.sink            sa1,
	ss_bus_if.sink                ss,
	output logic [ROM_ADDR_W-1:0] rom_addr,
	output logic                  rom_ce_n,
	output logic                  rom_oe_n,
	output logic                  rom_word
);
	import cart_pkg::*;

	logic [ROM_ADDR_W-1:0] sel_addr;
	logic                  sel_ce_n;
	logic                  sel_oe_n;
	logic                  sel_word;

	always_comb begin
		case (map_sel)
			MAP_GSU: begin
				sel_addr = gsu.rom_addr;
				sel_ce_n = gsu.rom_ce_n;
				sel_oe_n = gsu.rom_oe_n;
				sel_word = gsu.rom_word;
			end
			MAP_SA1: begin
				sel_addr = sa1.rom_addr;
				sel_ce_n = sa1.rom_ce_n;
				sel_oe_n = sa1.rom_oe_n;
				sel_word = sa1.rom_word;
			end
			default: begin
				sel_addr = base.rom_addr;
				sel_ce_n = base.rom_ce_n;
				sel_oe_n = base.rom_oe_n;
				sel_word = base.rom_word;
			end
		endcase
		// Only the address moves, strobes stay with the mapper.
		if (ss.rom_ovr)
			sel_addr = ss.rom_addr;
	end

	always_ff @(posedge mclk) begin
		if (rst) begin
			rom_addr <= '0;
			rom_ce_n <= 1'b1;
			rom_oe_n <= 1'b1;
			rom_word <= 1'b0;
		end else begin
			rom_addr <= sel_addr;
			rom_ce_n <= sel_ce_n;
			rom_oe_n <= sel_oe_n;
			rom_word <= sel_word;
		end
	end

endmodule

`default_nettype wire

/* design/sram_bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_bus_mux #(
	parameter int BSRAM_ADDR_W = bus_pkg::BSRAM_ADDR_W
) (
	input  logic                             mclk,
	input  logic                             rst,
	input  cart_pkg::map_sel_t               map_sel,
	mapper_bus_if.sink                       base,
	mapper_bus_if.sink                       gsu,
	mapper_bus_if.sink                       sa1,
	ss_bus_if.sink                           ss,
	input  logic [bus_pkg::ARAM_ADDR_W-1:0]  snd_aram_addr,
	input  bus_pkg::data_t                   snd_aram_d,
	input  logic                             snd_aram_ce_n,
	input  logic                             snd_aram_oe_n,
	input  logic                             snd_aram_we_n,
	output logic [BSRAM_ADDR_W-1:0]          bsram_addr,
	output bus_pkg::data_t                   bsram_d,
	output logic                             bsram_ce_n,
	output logic                             bsram_oe_n,
	output logic                             bsram_we_n,
	output logic [bus_pkg::ARAM_ADDR_W-1:0]  aram_addr,
	output bus_pkg::data_t                   aram_d,
	output logic                             aram_ce_n,
	output logic                             aram_oe_n,
	output logic                             aram_we_n
);
	import cart_pkg::*;
	import bus_pkg::*;

	logic [BSRAM_ADDR_W-1:0] bs_addr;
	data_t                   bs_d;
	logic                    bs_ce_n;
	logic                    bs_oe_n;
	logic                    bs_we_n;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Backup SRAM select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (map_sel)
			MAP_GSU: {bs_addr, bs_d, bs_ce_n, bs_oe_n, bs_we_n} = {gsu.bsram_addr,
				gsu.bsram_d, gsu.bsram_ce_n, gsu.bsram_oe_n, gsu.bsram_we_n};
			MAP_SA1: {bs_addr, bs_d, bs_ce_n, bs_oe_n, bs_we_n} = {sa1.bsram_addr,
				sa1.bsram_d, sa1.bsram_ce_n, sa1.bsram_oe_n, sa1.bsram_we_n};
			default: {bs_addr, bs_d, bs_ce_n, bs_oe_n, bs_we_n} = {base.bsram_addr,
				base.bsram_d, base.bsram_ce_n, base.bsram_oe_n, base.bsram_we_n};
		endcase
		if (ss.bsram_sel) begin
			bs_addr = BSRAM_ADDR_W'(ss.ext_addr);
			bs_d    = ss.ss_do;
			bs_ce_n = 1'b0;
			bs_oe_n = ss.pard_n;
			bs_we_n = ss.pawr_n;
		end
	end

	always_ff @(posedge mclk) begin
		if (rst) begin
			bsram_addr <= '0;
			bsram_d    <= '0;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
		end else begin
			bsram_addr <= bs_addr;
			bsram_d    <= bs_d;
			bsram_ce_n <= bs_ce_n;
			bsram_oe_n <= bs_oe_n;
			bsram_we_n <= bs_we_n;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Audio RAM goes to the sound system unless the savestate engine has it.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge mclk) begin
		if (rst) begin
			aram_addr <= '0;
			aram_d    <= '0;
			aram_ce_n <= 1'b1;
			aram_oe_n <= 1'b1;
			aram_we_n <= 1'b1;
		end else if (ss.aram_sel) begin
			aram_addr <= ss.ext_addr[ARAM_ADDR_W-1:0];
			aram_d    <= ss.ss_do;
			aram_ce_n <= 1'b0;
			aram_oe_n <= ss.pard_n;
			aram_we_n <= ss.pawr_n;
		end else begin
			aram_addr <= snd_aram_addr;
			aram_d    <= snd_aram_d;
			aram_ce_n <= snd_aram_ce_n;
			aram_oe_n <= snd_aram_oe_n;
			aram_we_n <= snd_aram_we_n;
		end
	end

endmodule

`default_nettype wire

/* design/cpu_data_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_data_mux (
	input  logic               mclk,
	input  logic               rst,
	input  cart_pkg::map_sel_t map_sel,
	mapper_bus_if.sink         base,
	mapper_bus_if.sink         gsu,
	mapper_bus_if.sink         sa1,
	ss_bus_if.sink             ss,
	input  logic               msu_sel,
	input  bus_pkg::data_t     msu_do,
	output bus_pkg::data_t     cpu_di,
	output logic               irq_n
);
	import cart_pkg::*;
	import bus_pkg::*;

	data_t map_do;
	logic  map_irq_n;

	always_comb begin
		case (map_sel)
			MAP_GSU: {map_do, map_irq_n} = {gsu.cpu_do, gsu.irq_n};
			MAP_SA1: {map_do, map_irq_n} = {sa1.cpu_do, sa1.irq_n};
			default: {map_do, map_irq_n} = {base.cpu_do, base.irq_n};
		endcase
	end

	always_ff @(posedge mclk) begin
		if (rst) begin
			cpu_di <= '0;
			irq_n  <= 1'b1;
		end else begin
			// Savestate wins over MSU.
			if (ss.do_ovr)
				cpu_di <= ss.ss_do;
			else if (msu_sel)
				cpu_di <= msu_do;
			else
				cpu_di <= map_do;
			irq_n <= map_irq_n;
		end
	end

endmodule

`default_nettype wire

/* design/cart_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_bus_top #(
	parameter int ROM_ADDR_W   = bus_pkg::ROM_ADDR_W,
	parameter int BSRAM_ADDR_W = bus_pkg::BSRAM_ADDR_W
) (
	input  logic                            mclk,
	input  logic                            rst,
	input  logic [7:0]                      cart_type,
	input  logic                            ss_busy,

	input  logic [ROM_ADDR_W-1:0]           base_rom_addr,
	input  logic                            base_rom_ce_n, base_rom_oe_n, base_rom_word,
	input  logic [BSRAM_ADDR_W-1:0]         base_bsram_addr,
	input  bus_pkg::data_t                  base_bsram_d, base_cpu_do,
	input  logic                            base_bsram_ce_n, base_bsram_oe_n, base_bsram_we_n,
	input  logic                            base_irq_n,

	input  logic [22:0]                     gsu_rom_addr,
	input  logic                            gsu_rom_ce_n, gsu_rom_oe_n, gsu_rom_word,
	input  logic [BSRAM_ADDR_W-1:0]         gsu_bsram_addr,
	input  bus_pkg::data_t                  gsu_bsram_d, gsu_cpu_do,
	input  logic                            gsu_bsram_ce_n, gsu_bsram_oe_n, gsu_bsram_we_n,
	input  logic                            gsu_irq_n,

	input  logic [22:0]                     sa1_rom_addr,
	input  logic                            sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word,
	input  logic [BSRAM_ADDR_W-1:0]         sa1_bsram_addr,
	input  bus_pkg::data_t                  sa1_bsram_d, sa1_cpu_do,
	input  logic                            sa1_bsram_ce_n, sa1_bsram_oe_n, sa1_bsram_we_n,
	input  logic                            sa1_irq_n,

	input  bus_pkg::data_t                  ss_do,
	input  logic [bus_pkg::EXT_ADDR_W-1:0]  ss_ext_addr,
	input  logic [ROM_ADDR_W-1:0]           ss_rom_addr,
	input  logic                            ss_aram_sel, ss_bsram_sel, ss_do_ovr, ss_rom_ovr,
	input  logic                            ss_pard_n, ss_pawr_n,

	input  logic [bus_pkg::ARAM_ADDR_W-1:0] snd_aram_addr,
	input  bus_pkg::data_t                  snd_aram_d,
	input  logic                            snd_aram_ce_n, snd_aram_oe_n, snd_aram_we_n,
	input  logic                            msu_sel,
	input  bus_pkg::data_t                  msu_do,

	output logic [ROM_ADDR_W-1:0]           rom_addr,
	output logic                            rom_ce_n, rom_oe_n, rom_word,
	output logic [BSRAM_ADDR_W-1:0]         bsram_addr,
	output bus_pkg::data_t                  bsram_d,
	output logic                            bsram_ce_n, bsram_oe_n, bsram_we_n,
	output logic [bus_pkg::ARAM_ADDR_W-1:0] aram_addr,
	output bus_pkg::data_t                  aram_d,
	output logic                            aram_ce_n, aram_oe_n, aram_we_n,
	output bus_pkg::data_t                  cpu_di,
	output logic                            irq_n,
	output logic                            ss_avail, turbo_allow, gsu_active
);
	import cart_pkg::*;

	cart_type_t cart_word;
	map_sel_t   map_sel;

	mapper_bus_if #(.ROM_ADDR_W(ROM_ADDR_W), .BSRAM_ADDR_W(BSRAM_ADDR_W)) base_bus ();
	mapper_bus_if #(.ROM_ADDR_W(ROM_ADDR_W), .BSRAM_ADDR_W(BSRAM_ADDR_W)) gsu_bus ();
	mapper_bus_if #(.ROM_ADDR_W(ROM_ADDR_W), .BSRAM_ADDR_W(BSRAM_ADDR_W)) sa1_bus ();
	ss_bus_if #(.ROM_ADDR_W(ROM_ADDR_W)) ss_bus ();

	assign cart_word = cart_type_t'(cart_type);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mapper buses.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign base_bus.rom_addr = base_rom_addr;
	assign {base_bus.rom_ce_n, base_bus.rom_oe_n, base_bus.rom_word} =
		{base_rom_ce_n, base_rom_oe_n, base_rom_word};
	assign {base_bus.bsram_addr, base_bus.bsram_d} = {base_bsram_addr, base_bsram_d};
	assign {base_bus.bsram_ce_n, base_bus.bsram_oe_n, base_bus.bsram_we_n} =
		{base_bsram_ce_n, base_bsram_oe_n, base_bsram_we_n};
	assign {base_bus.cpu_do, base_bus.irq_n} = {base_cpu_do, base_irq_n};

	// Coprocessor ROM addresses are 23 bits wide.
	assign gsu_bus.rom_addr = ROM_ADDR_W'(gsu_rom_addr);
	assign {gsu_bus.rom_ce_n, gsu_bus.rom_oe_n, gsu_bus.rom_word} =
		{gsu_rom_ce_n, gsu_rom_oe_n, gsu_rom_word};
	assign {gsu_bus.bsram_addr, gsu_bus.bsram_d} = {gsu_bsram_addr, gsu_bsram_d};
	assign {gsu_bus.bsram_ce_n, gsu_bus.bsram_oe_n, gsu_bus.bsram_we_n} =
		{gsu_bsram_ce_n, gsu_bsram_oe_n, gsu_bsram_we_n};
	assign {gsu_bus.cpu_do, gsu_bus.irq_n} = {gsu_cpu_do, gsu_irq_n};

	assign sa1_bus.rom_addr = ROM_ADDR_W'(sa1_rom_addr);
	assign {sa1_bus.rom_ce_n, sa1_bus.rom_oe_n, sa1_bus.rom_word} =
		{sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word};
	assign {sa1_bus.bsram_addr, sa1_bus.bsram_d} = {sa1_bsram_addr, sa1_bsram_d};
	assign {sa1_bus.bsram_ce_n, sa1_bus.bsram_oe_n, sa1_bus.bsram_we_n} =
		{sa1_bsram_ce_n, sa1_bsram_oe_n, sa1_bsram_we_n};
	assign {sa1_bus.cpu_do, sa1_bus.irq_n} = {sa1_cpu_do, sa1_irq_n};

	assign {ss_bus.ss_do, ss_bus.ext_addr, ss_bus.rom_addr} = {ss_do, ss_ext_addr, ss_rom_addr};
	assign {ss_bus.aram_sel, ss_bus.bsram_sel, ss_bus.do_ovr, ss_bus.rom_ovr} =
		{ss_aram_sel, ss_bsram_sel, ss_do_ovr, ss_rom_ovr};
	assign {ss_bus.pard_n, ss_bus.pawr_n} = {ss_pard_n, ss_pawr_n};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control and output muxes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	map_control u_map_control (
		.mclk(mclk), .rst(rst), .cart_type(cart_word), .ss_busy(ss_busy),
		.map_sel(map_sel), .ss_avail(ss_avail), .turbo_allow(turbo_allow),
		.gsu_active(gsu_active)
	);

	rom_bus_mux #(.ROM_ADDR_W(ROM_ADDR_W)) u_rom_bus_mux (
		.mclk(mclk), .rst(rst), .map_sel(map_sel),
		.base(base_bus), .gsu(gsu_bus), .sa1(sa1_bus), .ss(ss_bus),
		.rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_oe_n(rom_oe_n), .rom_word(rom_word)
	);

	sram_bus_mux #(.BSRAM_ADDR_W(BSRAM_ADDR_W)) u_sram_bus_mux (
		.mclk(mclk), .rst(rst), .map_sel(map_sel),
		.base(base_bus), .gsu(gsu_bus), .sa1(sa1_bus), .ss(ss_bus),
		.snd_aram_addr(snd_aram_addr), .snd_aram_d(snd_aram_d),
		.snd_aram_ce_n(snd_aram_ce_n), .snd_aram_oe_n(snd_aram_oe_n),
		.snd_aram_we_n(snd_aram_we_n),
		.bsram_addr(bsram_addr), .bsram_d(bsram_d), .bsram_ce_n(bsram_ce_n),
		.bsram_oe_n(bsram_oe_n), .bsram_we_n(bsram_we_n),
		.aram_addr(aram_addr), .aram_d(aram_d), .aram_ce_n(aram_ce_n),
		.aram_oe_n(aram_oe_n), .aram_we_n(aram_we_n)
	);

	cpu_data_mux u_cpu_data_mux (
		.mclk(mclk), .rst(rst), .map_sel(map_sel),
		.base(base_bus), .gsu(gsu_bus), .sa1(sa1_bus), .ss(ss_bus),
		.msu_sel(msu_sel), .msu_do(msu_do), .cpu_di(cpu_di), .irq_n(irq_n)
	);

endmodule

`default_nettype wire

/* testbench/tb_cart_tasks.svh */
`ifndef TB_CART_TASKS_SVH
`define TB_CART_TASKS_SVH

// Xorshift32 step.
function automatic logic [31:0] next_random();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare tasks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_data(input string what, input data_t expected, input data_t actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %02h actual %02h", what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "data byte mismatch");
	end
endtask

task automatic check_rom_addr(input string what, input logic [ROM_W-1:0] expected,
	input logic [ROM_W-1:0] actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %06h actual %06h", what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "ROM address mismatch");
	end
endtask

task automatic check_bsram_addr(input string what, input logic [BSRAM_W-1:0] expected,
	input logic [BSRAM_W-1:0] actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %05h actual %05h", what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "backup SRAM address mismatch");
	end
endtask

task automatic check_aram_addr(input string what, input logic [ARAM_ADDR_W-1:0] expected,
	input logic [ARAM_ADDR_W-1:0] actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %04h actual %04h", what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "audio RAM address mismatch");
	end
endtask

task automatic check_bit(input string what, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %b actual %b", what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "single bit mismatch");
	end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grouped checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_reset_state(input string tag);
	check_rom_addr({tag, " rom_addr"}, '0, rom_addr);
	check_bit({tag, " rom_ce_n"}, 1'b1, rom_ce_n);
	check_bit({tag, " rom_oe_n"}, 1'b1, rom_oe_n);
	check_bsram_addr({tag, " bsram_addr"}, '0, bsram_addr);
	check_data({tag, " bsram_d"}, 8'h00, bsram_d);
	check_bit({tag, " bsram_ce_n"}, 1'b1, bsram_ce_n);
	check_bit({tag, " bsram_oe_n"}, 1'b1, bsram_oe_n);
	check_bit({tag, " bsram_we_n"}, 1'b1, bsram_we_n);
	check_aram_addr({tag, " aram_addr"}, '0, aram_addr);
	check_data({tag, " aram_d"}, 8'h00, aram_d);
	check_bit({tag, " aram_ce_n"}, 1'b1, aram_ce_n);
	check_bit({tag, " aram_oe_n"}, 1'b1, aram_oe_n);
	check_bit({tag, " aram_we_n"}, 1'b1, aram_we_n);
	check_data({tag, " cpu_di"}, 8'h00, cpu_di);
	check_bit({tag, " irq_n"}, 1'b1, irq_n);
	check_bit({tag, " ss_avail"}, 1'b0, ss_avail);
	check_bit({tag, " turbo_allow"}, 1'b0, turbo_allow);
	check_bit({tag, " gsu_active"}, 1'b0, gsu_active);
endtask

task automatic check_mapper_outputs(input string tag, input map_sel_t which);
	logic [ROM_W-1:0]   exp_rom_addr;
	logic [2:0]         exp_rom_ctl;
	logic [BSRAM_W-1:0] exp_bsram_addr;
	data_t              exp_bsram_d;
	logic [2:0]         exp_bsram_ctl;
	data_t              exp_cpu_do;
	logic               exp_irq_n;
	case (which)
		MAP_GSU: begin
			exp_rom_addr = {{(ROM_W - 23){1'b0}}, gsu_rom_addr};
			exp_rom_ctl  = {gsu_rom_ce_n, gsu_rom_oe_n, gsu_rom_word};
			{exp_bsram_addr, exp_bsram_d} = {gsu_bsram_addr, gsu_bsram_d};
			exp_bsram_ctl = {gsu_bsram_ce_n, gsu_bsram_oe_n, gsu_bsram_we_n};
			{exp_cpu_do, exp_irq_n} = {gsu_cpu_do, gsu_irq_n};
		end
		MAP_SA1: begin
			exp_rom_addr = {{(ROM_W - 23){1'b0}}, sa1_rom_addr};
			exp_rom_ctl  = {sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word};
			{exp_bsram_addr, exp_bsram_d} = {sa1_bsram_addr, sa1_bsram_d};
			exp_bsram_ctl = {sa1_bsram_ce_n, sa1_bsram_oe_n, sa1_bsram_we_n};
			{exp_cpu_do, exp_irq_n} = {sa1_cpu_do, sa1_irq_n};
		end
		default: begin
			exp_rom_addr = base_rom_addr;
			exp_rom_ctl  = {base_rom_ce_n, base_rom_oe_n, base_rom_word};
			{exp_bsram_addr, exp_bsram_d} = {base_bsram_addr, base_bsram_d};
			exp_bsram_ctl = {base_bsram_ce_n, base_bsram_oe_n, base_bsram_we_n};
			{exp_cpu_do, exp_irq_n} = {base_cpu_do, base_irq_n};
		end
	endcase
	check_rom_addr({tag, " rom_addr"}, exp_rom_addr, rom_addr);
	check_bit({tag, " rom_ce_n"}, exp_rom_ctl[2], rom_ce_n);
	check_bit({tag, " rom_oe_n"}, exp_rom_ctl[1], rom_oe_n);
	check_bit({tag, " rom_word"}, exp_rom_ctl[0], rom_word);
	check_bsram_addr({tag, " bsram_addr"}, exp_bsram_addr, bsram_addr);
	check_data({tag, " bsram_d"}, exp_bsram_d, bsram_d);
	check_bit({tag, " bsram_ce_n"}, exp_bsram_ctl[2], bsram_ce_n);
	check_bit({tag, " bsram_oe_n"}, exp_bsram_ctl[1], bsram_oe_n);
	check_bit({tag, " bsram_we_n"}, exp_bsram_ctl[0], bsram_we_n);
	check_data({tag, " cpu_di"}, exp_cpu_do, cpu_di);
	check_bit({tag, " irq_n"}, exp_irq_n, irq_n);
endtask

// Both RAMs taken by the savestate engine.
task automatic check_ram_takeover(input string tag);
	check_bsram_addr({tag, " bsram_addr"}, BSRAM_W'(ss_ext_addr), bsram_addr);
	check_data({tag, " bsram_d"}, ss_do, bsram_d);
	check_bit({tag, " bsram_ce_n"}, 1'b0, bsram_ce_n);
	check_bit({tag, " bsram_oe_n"}, ss_pard_n, bsram_oe_n);
	check_bit({tag, " bsram_we_n"}, ss_pawr_n, bsram_we_n);
	check_aram_addr({tag, " aram_addr"}, ss_ext_addr[ARAM_ADDR_W-1:0], aram_addr);
	check_data({tag, " aram_d"}, ss_do, aram_d);
	check_bit({tag, " aram_ce_n"}, 1'b0, aram_ce_n);
	check_bit({tag, " aram_oe_n"}, ss_pard_n, aram_oe_n);
	check_bit({tag, " aram_we_n"}, ss_pawr_n, aram_we_n);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic test_reset();
	repeat (2) @(posedge mclk);
	@(negedge mclk);
	check_reset_state("reset_hold");
	repeat (2) @(posedge mclk);
	rst <= 1'b0;
	wait_outputs(1);
	check_reset_state("reset_release");
endtask

task automatic test_base_mapper();
	@(posedge mclk);
	cart_type <= {CHIP_NONE, 4'h1};
	ss_busy   <= 1'b0;
	drive_random_mappers();
	wait_outputs(2);
	check_mapper_outputs("base_select", MAP_BASE);
	check_bit("base_select ss_avail", 1'b1, ss_avail);
	check_bit("base_select turbo_allow", 1'b1, turbo_allow);
	check_bit("base_select gsu_active", 1'b0, gsu_active);
	repeat (3) begin
		@(posedge mclk);
		drive_random_mappers();
		wait_outputs(1);
		check_mapper_outputs("base_update", MAP_BASE);
	end
endtask

task automatic test_coprocessor_select();
	@(posedge mclk);
	cart_type <= {CHIP_GSU, 4'h0};
	drive_random_mappers();
	wait_outputs(2);
	check_mapper_outputs("gsu_select", MAP_GSU);
	check_bit("gsu_select gsu_active", 1'b1, gsu_active);
	check_bit("gsu_select ss_avail", 1'b1, ss_avail);
	@(posedge mclk);
	cart_type <= {CHIP_SA1, 4'h3};
	drive_random_mappers();
	wait_outputs(2);
	check_mapper_outputs("sa1_select", MAP_SA1);
	check_bit("sa1_select ss_avail", 1'b1, ss_avail);
	check_bit("sa1_select turbo_allow", 1'b0, turbo_allow);
	check_bit("sa1_select gsu_active", 1'b0, gsu_active);
	// Chip ID 4'hA in the DSP class.
	@(posedge mclk);
	cart_type <= {DSP_CLASS, 6'h25};
	wait_outputs(1);
	check_bit("dsp_class ss_avail", 1'b1, ss_avail);
	check_bit("dsp_class turbo_allow", 1'b1, turbo_allow);
	@(posedge mclk);
	cart_type <= {4'h3, 4'h5};
	wait_outputs(1);
	check_bit("chip3 ss_avail", 1'b0, ss_avail);
	@(posedge mclk);
	ss_busy <= 1'b1;
	wait_outputs(1);
	check_bit("ss_busy turbo_allow", 1'b0, turbo_allow);
	@(posedge mclk);
	ss_busy <= 1'b0;
	wait_outputs(1);
	check_bit("ss_idle turbo_allow", 1'b1, turbo_allow);
endtask

task automatic test_cpu_data_priority();
	logic [31:0] r;
	r = next_random();
	@(posedge mclk);
	cart_type <= {CHIP_NONE, 4'h0};
	drive_random_mappers();
	ss_do     <= r[7:0];
	msu_do    <= ~r[7:0];
	ss_do_ovr <= 1'b1;
	msu_sel   <= 1'b1;
	wait_outputs(2);
	check_data("ovr_and_msu cpu_di", ss_do, cpu_di);
	@(posedge mclk);
	ss_do_ovr <= 1'b0;
	wait_outputs(1);
	check_data("msu_only cpu_di", msu_do, cpu_di);
	@(posedge mclk);
	msu_sel <= 1'b0;
	wait_outputs(1);
	check_data("mapper cpu_di", base_cpu_do, cpu_di);
	check_bit("mapper irq_n", base_irq_n, irq_n);
endtask

task automatic test_savestate_override();
	logic [31:0] r;
	r = next_random();
	@(posedge mclk);
	drive_random_mappers();
	ss_ext_addr   <= EXT_ADDR_W'(r);
	ss_do         <= r[31:24];
	snd_aram_addr <= ARAM_ADDR_W'(next_random());
	snd_aram_d    <= data_t'(next_random());
	{snd_aram_ce_n, snd_aram_oe_n, snd_aram_we_n} <= 3'b001;
	{ss_bsram_sel, ss_aram_sel} <= 2'b11;
	{ss_pard_n, ss_pawr_n} <= 2'b01;
	wait_outputs(1);
	check_ram_takeover("ss_read");
	@(posedge mclk);
	{ss_pard_n, ss_pawr_n} <= 2'b10;
	ss_rom_ovr  <= 1'b1;
	ss_rom_addr <= ROM_W'(next_random());
	wait_outputs(1);
	check_ram_takeover("ss_write");
	check_rom_addr("rom_ovr rom_addr", ss_rom_addr, rom_addr);
	check_bit("rom_ovr rom_ce_n", base_rom_ce_n, rom_ce_n);
	check_bit("rom_ovr rom_oe_n", base_rom_oe_n, rom_oe_n);
	@(posedge mclk);
	{ss_bsram_sel, ss_aram_sel, ss_rom_ovr} <= 3'b000;
	wait_outputs(1);
	check_mapper_outputs("ss_release", MAP_BASE);
	check_aram_addr("ss_release aram_addr", snd_aram_addr, aram_addr);
	check_data("ss_release aram_d", snd_aram_d, aram_d);
	check_bit("ss_release aram_ce_n", snd_aram_ce_n, aram_ce_n);
	check_bit("ss_release aram_oe_n", snd_aram_oe_n, aram_oe_n);
	check_bit("ss_release aram_we_n", snd_aram_we_n, aram_we_n);
endtask

`endif

/* testbench/tb_cart_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_bus;
	import bus_pkg::*;
	import cart_pkg::*;

	localparam int ROM_W      = ROM_ADDR_W;
	localparam int BSRAM_W    = BSRAM_ADDR_W;
	localparam int CLK_PERIOD = 100;

	// Cycle budget of each test.
	localparam int RESET_CYCLES    = 6;
	localparam int BASE_CYCLES     = 12;
	localparam int COPROC_CYCLES   = 16;
	localparam int PRIORITY_CYCLES = 8;
	localparam int OVERRIDE_CYCLES = 8;
	localparam int CYCLE_BUDGET    = RESET_CYCLES + BASE_CYCLES + COPROC_CYCLES +
		PRIORITY_CYCLES + OVERRIDE_CYCLES;

	logic        mclk = 1'b0;
	logic        rst;
	logic [7:0]  cart_type;
	logic        ss_busy;
	logic [31:0] rng_state = 32'h5b5098d8;

	logic [ROM_W-1:0]   base_rom_addr;
	logic               base_rom_ce_n, base_rom_oe_n, base_rom_word;
	logic [BSRAM_W-1:0] base_bsram_addr;
	data_t              base_bsram_d, base_cpu_do;
	logic               base_bsram_ce_n, base_bsram_oe_n, base_bsram_we_n, base_irq_n;

	logic [22:0]        gsu_rom_addr;
	logic               gsu_rom_ce_n, gsu_rom_oe_n, gsu_rom_word;
	logic [BSRAM_W-1:0] gsu_bsram_addr;
	data_t              gsu_bsram_d, gsu_cpu_do;
	logic               gsu_bsram_ce_n, gsu_bsram_oe_n, gsu_bsram_we_n, gsu_irq_n;

	logic [22:0]        sa1_rom_addr;
	logic               sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word;
	logic [BSRAM_W-1:0] sa1_bsram_addr;
	data_t              sa1_bsram_d, sa1_cpu_do;
	logic               sa1_bsram_ce_n, sa1_bsram_oe_n, sa1_bsram_we_n, sa1_irq_n;

	data_t                  ss_do;
	logic [EXT_ADDR_W-1:0]  ss_ext_addr;
	logic [ROM_W-1:0]       ss_rom_addr;
	logic                   ss_aram_sel, ss_bsram_sel, ss_do_ovr, ss_rom_ovr;
	logic                   ss_pard_n, ss_pawr_n;
	logic [ARAM_ADDR_W-1:0] snd_aram_addr;
	data_t                  snd_aram_d;
	logic                   snd_aram_ce_n, snd_aram_oe_n, snd_aram_we_n;
	logic                   msu_sel;
	data_t                  msu_do;

	logic [ROM_W-1:0]       rom_addr;
	logic                   rom_ce_n, rom_oe_n, rom_word;
	logic [BSRAM_W-1:0]     bsram_addr;
	data_t                  bsram_d;
	logic                   bsram_ce_n, bsram_oe_n, bsram_we_n;
	logic [ARAM_ADDR_W-1:0] aram_addr;
	data_t                  aram_d;
	logic                   aram_ce_n, aram_oe_n, aram_we_n;
	data_t                  cpu_di;
	logic                   irq_n;
	logic                   ss_avail, turbo_allow, gsu_active;

	cart_bus_top #(.ROM_ADDR_W(ROM_W), .BSRAM_ADDR_W(BSRAM_W)) dut (.*);

	always #(CLK_PERIOD / 2) mclk = ~mclk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Chip 3 and a busy savestate keep every flag low.
	task automatic init_inputs();
		rst       <= 1'b1;
		cart_type <= 8'h30;
		ss_busy   <= 1'b1;
		{base_rom_addr, base_bsram_addr, base_bsram_d, base_cpu_do} <= '0;
		{gsu_rom_addr, gsu_bsram_addr, gsu_bsram_d, gsu_cpu_do} <= '0;
		{sa1_rom_addr, sa1_bsram_addr, sa1_bsram_d, sa1_cpu_do} <= '0;
		{base_rom_ce_n, base_rom_oe_n, base_rom_word} <= 3'b110;
		{gsu_rom_ce_n, gsu_rom_oe_n, gsu_rom_word} <= 3'b110;
		{sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word} <= 3'b110;
		{base_bsram_ce_n, base_bsram_oe_n, base_bsram_we_n, base_irq_n} <= 4'hf;
		{gsu_bsram_ce_n, gsu_bsram_oe_n, gsu_bsram_we_n, gsu_irq_n} <= 4'hf;
		{sa1_bsram_ce_n, sa1_bsram_oe_n, sa1_bsram_we_n, sa1_irq_n} <= 4'hf;
		{ss_do, ss_ext_addr, ss_rom_addr} <= '0;
		{ss_aram_sel, ss_bsram_sel, ss_do_ovr, ss_rom_ovr} <= 4'h0;
		{ss_pard_n, ss_pawr_n} <= 2'b11;
		{snd_aram_addr, snd_aram_d} <= '0;
		{snd_aram_ce_n, snd_aram_oe_n, snd_aram_we_n} <= 3'b111;
		msu_sel <= 1'b0;
		msu_do  <= '0;
	endtask

	task automatic drive_random_mappers();
		logic [31:0] r;
		base_rom_addr   <= ROM_W'(next_random());
		base_bsram_addr <= BSRAM_W'(next_random());
		r = next_random();
		{base_bsram_d, base_cpu_do} <= r[15:0];
		{base_rom_ce_n, base_rom_oe_n, base_rom_word, base_bsram_ce_n, base_bsram_oe_n,
			base_bsram_we_n, base_irq_n} <= r[22:16];
		gsu_rom_addr   <= 23'(next_random());
		gsu_bsram_addr <= BSRAM_W'(next_random());
		r = next_random();
		{gsu_bsram_d, gsu_cpu_do} <= r[15:0];
		{gsu_rom_ce_n, gsu_rom_oe_n, gsu_rom_word, gsu_bsram_ce_n, gsu_bsram_oe_n,
			gsu_bsram_we_n, gsu_irq_n} <= r[22:16];
		sa1_rom_addr   <= 23'(next_random());
		sa1_bsram_addr <= BSRAM_W'(next_random());
		r = next_random();
		{sa1_bsram_d, sa1_cpu_do} <= r[15:0];
		{sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word, sa1_bsram_ce_n, sa1_bsram_oe_n,
			sa1_bsram_we_n, sa1_irq_n} <= r[22:16];
	endtask

	// Outputs are read at the falling edge, away from the drive edge.
	task automatic wait_outputs(input int cycles);
		repeat (cycles) @(posedge mclk);
		@(negedge mclk);
	endtask

	`include "tb_cart_tasks.svh"

	initial begin
		#(2 * CYCLE_BUDGET * CLK_PERIOD);
		$display("Watchdog expired: tests still running after %0d cycles", 2 * CYCLE_BUDGET);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped by the watchdog");
	end

	initial begin
		init_inputs();
		test_reset();
		test_base_mapper();
		test_coprocessor_select();
		test_cpu_data_priority();
		test_savestate_override();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+testbench
design/cart_pkg.sv
design/bus_pkg.sv
design/cart_if.sv
design/map_control.sv
design/rom_bus_mux.sv
design/sram_bus_mux.sv
design/cpu_data_mux.sv
design/cart_bus_top.sv
testbench/tb_cart_bus.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_cart_bus \
		-f files.f -Mdir obj_dir -o sim_tb_cart_bus
	./obj_dir/sim_tb_cart_bus | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
